/* logic/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// bus widths
`define CSR_ADDR_W 16
`define CSR_DATA_W 32
`define CSR_STRB_W 4

// the block decodes one 256 byte page starting here
`define CSR_BASE_ADDR 16'h1000
`define CSR_DEFAULT_RDATA 32'hDEAD_BEAF
`define CSR_ID_VALUE 32'hC5B0_0001

// register offsets inside the page
`define CSR_OFS_CTRL 8'h00
`define CSR_OFS_TRIGGER 8'h04
`define CSR_OFS_STATUS 8'h08
`define CSR_OFS_LIMIT 8'h0C
`define CSR_OFS_ID 8'h10
`define CSR_OFS_WINDOW 8'h20 // four words forwarded to the sub-block

`define CSR_EVENT_W 4

`endif

/* logic/csr_bus_pkg.sv */
`default_nettype none

package csr_bus_pkg;

  // ----------------------------------------
  // internal request bus
  // ----------------------------------------

  // bit 1 marks a valid access, bit 0 the direction
  typedef enum logic [1:0] {
    CSR_READ  = 2'b10,
    CSR_WRITE = 2'b11
  } csr_access_e;

  // the high bit of the status means error
  typedef enum logic [1:0] {
    CSR_OKAY   = 2'b00,
    CSR_SLVERR = 2'b10
  } csr_status_e;

endpackage

`default_nettype wire

/* logic/csr_map_pkg.sv */
`default_nettype none

package csr_map_pkg;

  // ----------------------------------------
  // register map
  // ----------------------------------------

  // target of a decoded address
  typedef enum logic [2:0] {
    REG_CTRL,
    REG_TRIGGER,
    REG_STATUS,
    REG_LIMIT,
    REG_ID,
    REG_WINDOW,
    REG_NONE
  } csr_reg_e;

  // word inside the forwarded window
  typedef logic [1:0] csr_win_idx_t;

endpackage

`default_nettype wire

/* logic/csr_apb_front.sv */
`default_nettype none
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_apb_front (
  input  wire                            clk,
  input  wire                            i_arst_n,
  input  wire                            i_psel,
  input  wire                            i_penable,
  input  wire                            i_pwrite,
  input  wire [`CSR_ADDR_W-1:0]          i_paddr,
  input  wire [`CSR_DATA_W-1:0]          i_pwdata,
  input  wire [`CSR_STRB_W-1:0]          i_pstrb,
  output logic                           o_pready,
  output logic [`CSR_DATA_W-1:0]         o_prdata,
  output logic                           o_pslverr,
  output logic                           o_req_valid,
  output csr_bus_pkg::csr_access_e       o_req_access,
  output logic [`CSR_ADDR_W-1:0]         o_req_addr,
  output logic [`CSR_DATA_W-1:0]         o_req_wdata,
  output logic [`CSR_STRB_W-1:0]         o_req_strb,
  input  wire                            i_req_ready,
  input  wire csr_bus_pkg::csr_status_e  i_rsp_status,
  input  wire [`CSR_DATA_W-1:0]          i_rsp_rdata
);
  import csr_bus_pkg::*;

  typedef enum logic [1:0] {IDLE, BUSY, DONE} state_e;

  state_e state_q;
  logic   accept;

  assign o_req_valid = (state_q == BUSY);
  assign accept      = o_req_valid && i_req_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= IDLE;
      o_pready  <= 1'b0;
      o_pslverr <= 1'b0;
    end else begin
      o_pready <= accept; // one wait state after the accept
      case (state_q)
        IDLE:    if (i_psel && i_penable) state_q <= BUSY;
        BUSY:    if (i_req_ready) state_q <= DONE;
        default: state_q <= IDLE; // transfer ends with pready
      endcase
      if (accept) begin
        o_pslverr <= i_rsp_status[1];
      end
    end
  end

  // request register and the response data
  always_ff @(posedge clk) begin
    if (state_q == IDLE && i_psel && i_penable) begin
      o_req_access <= i_pwrite ? CSR_WRITE : CSR_READ;
      o_req_addr   <= i_paddr;
      o_req_wdata  <= i_pwdata;
      o_req_strb   <= i_pstrb;
    end
    if (accept) begin
      o_prdata <= i_rsp_rdata;
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_req_valid && !i_req_ready |=> o_req_valid && $stable(o_req_access) &&
      $stable(o_req_addr) && $stable(o_req_wdata) && $stable(o_req_strb));

  a_pready_done: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_pready |-> state_q == DONE);

endmodule

`default_nettype wire

/* logic/csr_decoder.sv */
`default_nettype none
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_decoder (
  input  wire                            clk,
  input  wire                            i_arst_n,
  input  wire                            i_req_valid,
  input  wire csr_bus_pkg::csr_access_e  i_req_access,
  input  wire [`CSR_ADDR_W-1:0]          i_req_addr,
  input  wire [`CSR_DATA_W-1:0]          i_req_wdata,
  input  wire [`CSR_STRB_W-1:0]          i_req_strb,
  output logic                           o_req_ready,
  output csr_bus_pkg::csr_status_e       o_rsp_status,
  output logic [`CSR_DATA_W-1:0]         o_rsp_rdata,
  output logic                           o_ctrl_sel,
  output logic                           o_trigger_sel,
  output logic                           o_limit_sel,
  output logic                           o_status_sel,
  output logic                           o_wr_en,
  output logic [`CSR_DATA_W-1:0]         o_wdata,
  output logic [`CSR_STRB_W-1:0]         o_wstrb,
  input  wire [`CSR_DATA_W-1:0]          i_ctrl_rdata,
  input  wire [`CSR_DATA_W-1:0]          i_limit_rdata,
  input  wire [`CSR_DATA_W-1:0]          i_status_rdata,
  output logic                           o_win_valid,
  output logic                           o_win_write,
  output csr_map_pkg::csr_win_idx_t      o_win_idx,
  output logic [`CSR_DATA_W-1:0]         o_win_wdata,
  output logic [`CSR_STRB_W-1:0]         o_win_strb,
  input  wire                            i_win_ready,
  input  wire [`CSR_DATA_W-1:0]          i_win_rdata
);
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  logic [`CSR_ADDR_W-1:0] rel_addr;
  logic [7:0]             word_ofs;
  csr_reg_e               target;

  assign rel_addr = i_req_addr - `CSR_BASE_ADDR;
  assign word_ofs = {rel_addr[7:2], 2'b00}; // byte lanes come from the strobes

  always_comb begin
    target = REG_NONE;
    if (rel_addr[`CSR_ADDR_W-1:8] == '0) begin // outside the page stays unmapped
      case (word_ofs)
        `CSR_OFS_CTRL:    target = REG_CTRL;
        `CSR_OFS_TRIGGER: target = REG_TRIGGER;
        `CSR_OFS_STATUS:  target = REG_STATUS;
        `CSR_OFS_LIMIT:   target = REG_LIMIT;
        `CSR_OFS_ID:      target = REG_ID;
        default: begin
          if ({word_ofs[7:4], 4'h0} == `CSR_OFS_WINDOW) begin
            target = REG_WINDOW;
          end
        end
      endcase
    end
  end

  // ----------------------------------------
  // local registers
  // ----------------------------------------
  assign o_ctrl_sel    = i_req_valid && (target == REG_CTRL);
  assign o_trigger_sel = i_req_valid && (target == REG_TRIGGER);
  assign o_limit_sel   = i_req_valid && (target == REG_LIMIT);
  assign o_status_sel  = i_req_valid && (target == REG_STATUS);
  assign o_wr_en       = i_req_valid && (i_req_access == CSR_WRITE);
  assign o_wdata       = i_req_wdata;
  assign o_wstrb       = i_req_strb;

  // ----------------------------------------
  // forwarded window
  // ----------------------------------------
  assign o_win_valid = i_req_valid && (target == REG_WINDOW);
  assign o_win_write = (i_req_access == CSR_WRITE);
  assign o_win_idx   = word_ofs[3:2];
  assign o_win_wdata = i_req_wdata;
  assign o_win_strb  = i_req_strb;

  assign o_req_ready  = (target == REG_WINDOW) ? i_win_ready : 1'b1;
  assign o_rsp_status = (target == REG_NONE) ? CSR_SLVERR : CSR_OKAY;

  always_comb begin
    case (target)
      REG_CTRL:    o_rsp_rdata = i_ctrl_rdata;
      REG_STATUS:  o_rsp_rdata = i_status_rdata;
      REG_LIMIT:   o_rsp_rdata = i_limit_rdata;
      REG_ID:      o_rsp_rdata = `CSR_ID_VALUE;
      REG_WINDOW:  o_rsp_rdata = i_win_rdata;
      REG_TRIGGER: o_rsp_rdata = '0; // trigger bits only pulse
      default:     o_rsp_rdata = `CSR_DEFAULT_RDATA;
    endcase
  end

  a_win_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_win_valid && !i_win_ready |=> o_win_valid);

endmodule

`default_nettype wire

/* logic/csr_control_regs.sv */
`default_nettype none
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_control_regs (
  input  wire                     clk,
  input  wire                     i_arst_n,
  input  wire                     i_ctrl_sel,
  input  wire                     i_trigger_sel,
  input  wire                     i_limit_sel,
  input  wire                     i_wr_en,
  input  wire [`CSR_DATA_W-1:0]   i_wdata,
  input  wire [`CSR_STRB_W-1:0]   i_wstrb,
  output logic [`CSR_DATA_W-1:0]  o_ctrl_rdata,
  output logic [`CSR_DATA_W-1:0]  o_limit_rdata,
  output logic [3:0]              o_mode,
  output logic [3:0]              o_irq_en,
  output logic [1:0]              o_option,
  output logic                    o_lock,
  output logic [7:0]              o_limit,
  output logic [3:0]              o_trigger
);

  logic ctrl_wr;
  logic trigger_wr;
  logic limit_wr;

  assign ctrl_wr    = i_ctrl_sel && i_wr_en;
  assign trigger_wr = i_trigger_sel && i_wr_en && i_wstrb[0];
  assign limit_wr   = i_limit_sel && i_wr_en && i_wstrb[0] && !o_lock;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_mode    <= 4'h0;
      o_irq_en  <= 4'h0;
      o_lock    <= 1'b0;
      o_option  <= 2'h1;
      o_limit   <= 8'h00;
      o_trigger <= 4'h0;
    end else begin
      if (ctrl_wr && i_wstrb[0]) begin
        o_mode   <= i_wdata[3:0];
        o_irq_en <= i_wdata[7:4];
      end
      if (ctrl_wr && i_wstrb[1]) begin
        o_lock   <= i_wdata[8];
        o_option <= i_wdata[13:12];
      end
      if (limit_wr) begin
        o_limit <= i_wdata[7:0]; // lock freezes the limit
      end
      o_trigger <= trigger_wr ? i_wdata[3:0] : 4'h0; // single cycle pulse
    end
  end

  // ----------------------------------------
  // read back
  // ----------------------------------------
  assign o_ctrl_rdata  = {18'h0, o_option, 3'h0, o_lock, o_irq_en, o_mode};
  assign o_limit_rdata = {24'h0, o_limit};

endmodule

`default_nettype wire

/* logic/csr_event_regs.sv */
`default_nettype none
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_event_regs (
  input  wire                     clk,
  input  wire                     i_arst_n,
  input  wire                     i_status_sel,
  input  wire                     i_wr_en,
  input  wire [`CSR_DATA_W-1:0]   i_wdata,
  input  wire [`CSR_STRB_W-1:0]   i_wstrb,
  input  wire [`CSR_EVENT_W-1:0]  i_event,
  input  wire [3:0]               i_hw_status,
  input  wire [`CSR_EVENT_W-1:0]  i_irq_en,
  output logic [`CSR_DATA_W-1:0]  o_status_rdata,
  output logic                    o_irq
);

  logic [`CSR_EVENT_W-1:0] flags_q;
  logic [`CSR_EVENT_W-1:0] clear;
  logic [`CSR_EVENT_W-1:0] flags_next;

  // ----------------------------------------
  // event flags
  // ----------------------------------------

  // software writes one to clear, only through byte 0
  always_comb begin
    clear = '0;
    if (i_status_sel && i_wr_en && i_wstrb[0]) begin
      clear = i_wdata[`CSR_EVENT_W-1:0];
    end
  end

  // an event in the same cycle as its clear keeps the flag set
  assign flags_next = (flags_q & ~clear) | i_event;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      flags_q <= '0;
      o_irq   <= 1'b0;
    end else begin
      flags_q <= flags_next;
      o_irq   <= |(flags_next & i_irq_en);
    end
  end

  // ----------------------------------------
  // read back
  // ----------------------------------------

  // hardware status sits in bits 19:16
  assign o_status_rdata = {12'h000, i_hw_status, 12'h000, flags_q};

  a_flag_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    ((flags_q ^ $past(flags_q)) & ~$past(i_event | clear)) == '0);

endmodule

`default_nettype wire

/* logic/csr_window_regs.sv */
`default_nettype none
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_window_regs (
  input  wire                         clk,
  input  wire                         i_arst_n,
  input  wire                         i_win_valid,
  input  wire                         i_win_write,
  input  wire csr_map_pkg::csr_win_idx_t i_win_idx,
  input  wire [`CSR_DATA_W-1:0]       i_win_wdata,
  input  wire [`CSR_STRB_W-1:0]       i_win_strb,
  output logic                        o_win_ready,
  output logic [`CSR_DATA_W-1:0]      o_win_rdata
);

  logic [`CSR_DATA_W-1:0] words_q [4];
  logic                   first;

  assign first = i_win_valid && !o_win_ready; // request seen, not yet acknowledged

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_win_ready <= 1'b0;
      for (int w = 0; w < 4; w++) begin
        words_q[w] <= '0;
      end
    end else begin
      o_win_ready <= first;
      // writes land with the acknowledge
      if (i_win_valid && o_win_ready && i_win_write) begin
        for (int b = 0; b < `CSR_STRB_W; b++) begin
          if (i_win_strb[b]) begin
            words_q[i_win_idx][8*b +: 8] <= i_win_wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // read data lines up with ready
  always_ff @(posedge clk) begin
    if (first) begin
      o_win_rdata <= words_q[i_win_idx];
    end
  end

  a_ready_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_win_ready |-> i_win_valid);

endmodule

`default_nettype wire

/* logic/csr_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_top (
  input  wire                     clk,
  input  wire                     i_arst_n,
  input  wire                     i_psel,
  input  wire                     i_penable,
  input  wire                     i_pwrite,
  input  wire [`CSR_ADDR_W-1:0]   i_paddr,
  input  wire [`CSR_DATA_W-1:0]   i_pwdata,
  input  wire [`CSR_STRB_W-1:0]   i_pstrb,
  output logic                    o_pready,
  output logic [`CSR_DATA_W-1:0]  o_prdata,
  output logic                    o_pslverr,
  input  wire [`CSR_EVENT_W-1:0]  i_event,
  input  wire [3:0]               i_hw_status,
  output logic [3:0]              o_mode,
  output logic [3:0]              o_irq_en,
  output logic [1:0]              o_option,
  output logic                    o_lock,
  output logic [7:0]              o_limit,
  output logic [3:0]              o_trigger,
  output logic                    o_irq
);
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  // request bus
  logic                   req_valid;
  csr_access_e            req_access;
  logic [`CSR_ADDR_W-1:0] req_addr;
  logic [`CSR_DATA_W-1:0] req_wdata;
  logic [`CSR_STRB_W-1:0] req_strb;
  logic                   req_ready;
  csr_status_e            rsp_status;
  logic [`CSR_DATA_W-1:0] rsp_rdata;

  // local register port
  logic                   ctrl_sel;
  logic                   trigger_sel;
  logic                   limit_sel;
  logic                   status_sel;
  logic                   wr_en;
  logic [`CSR_DATA_W-1:0] wdata;
  logic [`CSR_STRB_W-1:0] wstrb;
  logic [`CSR_DATA_W-1:0] ctrl_rdata;
  logic [`CSR_DATA_W-1:0] limit_rdata;
  logic [`CSR_DATA_W-1:0] status_rdata;

  // window port
  logic                   win_valid;
  logic                   win_write;
  csr_win_idx_t           win_idx;
  logic [`CSR_DATA_W-1:0] win_wdata;
  logic [`CSR_STRB_W-1:0] win_strb;
  logic                   win_ready;
  logic [`CSR_DATA_W-1:0] win_rdata;

  csr_apb_front u_front (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .i_pstrb      (i_pstrb),
    .o_pready     (o_pready),
    .o_prdata     (o_prdata),
    .o_pslverr    (o_pslverr),
    .o_req_valid  (req_valid),
    .o_req_access (req_access),
    .o_req_addr   (req_addr),
    .o_req_wdata  (req_wdata),
    .o_req_strb   (req_strb),
    .i_req_ready  (req_ready),
    .i_rsp_status (rsp_status),
    .i_rsp_rdata  (rsp_rdata)
  );

  csr_decoder u_decoder (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_req_valid    (req_valid),
    .i_req_access   (req_access),
    .i_req_addr     (req_addr),
    .i_req_wdata    (req_wdata),
    .i_req_strb     (req_strb),
    .o_req_ready    (req_ready),
    .o_rsp_status   (rsp_status),
    .o_rsp_rdata    (rsp_rdata),
    .o_ctrl_sel     (ctrl_sel),
    .o_trigger_sel  (trigger_sel),
    .o_limit_sel    (limit_sel),
    .o_status_sel   (status_sel),
    .o_wr_en        (wr_en),
    .o_wdata        (wdata),
    .o_wstrb        (wstrb),
    .i_ctrl_rdata   (ctrl_rdata),
    .i_limit_rdata  (limit_rdata),
    .i_status_rdata (status_rdata),
    .o_win_valid    (win_valid),
    .o_win_write    (win_write),
    .o_win_idx      (win_idx),
    .o_win_wdata    (win_wdata),
    .o_win_strb     (win_strb),
    .i_win_ready    (win_ready),
    .i_win_rdata    (win_rdata)
  );

  csr_control_regs u_control (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_ctrl_sel    (ctrl_sel),
    .i_trigger_sel (trigger_sel),
    .i_limit_sel   (limit_sel),
    .i_wr_en       (wr_en),
    .i_wdata       (wdata),
    .i_wstrb       (wstrb),
    .o_ctrl_rdata  (ctrl_rdata),
    .o_limit_rdata (limit_rdata),
    .o_mode        (o_mode),
    .o_irq_en      (o_irq_en),
    .o_option      (o_option),
    .o_lock        (o_lock),
    .o_limit       (o_limit),
    .o_trigger     (o_trigger)
  );

  csr_event_regs u_event (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_status_sel   (status_sel),
    .i_wr_en        (wr_en),
    .i_wdata        (wdata),
    .i_wstrb        (wstrb),
    .i_event        (i_event),
    .i_hw_status    (i_hw_status),
    .i_irq_en       (o_irq_en),
    .o_status_rdata (status_rdata),
    .o_irq          (o_irq)
  );

  csr_window_regs u_window (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_win_valid (win_valid),
    .i_win_write (win_write),
    .i_win_idx   (win_idx),
    .i_win_wdata (win_wdata),
    .i_win_strb  (win_strb),
    .o_win_ready (win_ready),
    .o_win_rdata (win_rdata)
  );

endmodule

`default_nettype wire

/* bench/csr_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_tb;
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int N_RANDOM    = 300;
  localparam int N_DIRECTED  = 250;
  localparam int WATCHDOG_NS = (N_RANDOM + N_DIRECTED) * 8 * CLK_PERIOD + 1000 * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'he7be;
  localparam logic [15:0] BAD_ADDR [9] = '{16'h1014, 16'h1018, 16'h101C, 16'h1030,
                                          16'h10FC, 16'h0000, 16'h0FFC, 16'h1100, 16'hFFFC};

  logic        clk = 1'b0;
  logic        i_arst_n;
  logic        i_psel;
  logic        i_penable;
  logic        i_pwrite;
  logic [15:0] i_paddr;
  logic [31:0] i_pwdata;
  logic [3:0]  i_pstrb;
  logic        o_pready;
  logic [31:0] o_prdata;
  logic        o_pslverr;
  logic [3:0]  i_event;
  logic [3:0]  i_hw_status;
  logic [3:0]  o_mode;
  logic [3:0]  o_irq_en;
  logic [1:0]  o_option;
  logic        o_lock;
  logic [7:0]  o_limit;
  logic [3:0]  o_trigger;
  logic        o_irq;

  // shadow of the register map
  logic [3:0]  sh_mode;
  logic [3:0]  sh_irq_en;
  logic [1:0]  sh_option;
  logic        sh_lock;
  logic [7:0]  sh_limit;
  logic [31:0] sh_win [4];
  logic [3:0]  m_flags;
  logic        m_irq;
  logic [3:0]  clear_pend; // clear bits seen by the event flags this cycle
  logic        events_on;
  logic        event_hold_en;
  logic [3:0]  event_hold;
  logic        hw_random;
  int          errors = 0;
  int          xfers = 0;
  int          tests = 0;
  int          test_err0;
  int          test_xfer0;

  csr_top dut (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
    .i_paddr (i_paddr), .i_pwdata (i_pwdata), .i_pstrb (i_pstrb),
    .o_pready (o_pready), .o_prdata (o_prdata), .o_pslverr (o_pslverr),
    .i_event (i_event), .i_hw_status (i_hw_status),
    .o_mode (o_mode), .o_irq_en (o_irq_en), .o_option (o_option), .o_lock (o_lock),
    .o_limit (o_limit), .o_trigger (o_trigger), .o_irq (o_irq)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // event flags are set by hardware and cleared by a one written to STATUS
  always @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      m_flags <= 4'h0;
      m_irq   <= 1'b0;
    end else begin
      m_flags <= (m_flags & ~clear_pend) | i_event;
      m_irq   <= |(((m_flags & ~clear_pend) | i_event) & sh_irq_en);
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [15:0] reg_addr(input logic [7:0] ofs);
    reg_addr = `CSR_BASE_ADDR + {8'h00, ofs};
  endfunction

  function automatic csr_reg_e decode_addr(input logic [15:0] addr);
    logic [15:0] rel;
    logic [7:0]  ofs;
    rel = addr - `CSR_BASE_ADDR;
    ofs = {rel[7:2], 2'b00};
    if (rel[15:8] != 8'h00) return REG_NONE;
    if (ofs == `CSR_OFS_CTRL) return REG_CTRL;
    if (ofs == `CSR_OFS_TRIGGER) return REG_TRIGGER;
    if (ofs == `CSR_OFS_STATUS) return REG_STATUS;
    if (ofs == `CSR_OFS_LIMIT) return REG_LIMIT;
    if (ofs == `CSR_OFS_ID) return REG_ID;
    if (ofs >= `CSR_OFS_WINDOW && ofs < `CSR_OFS_WINDOW + 8'h10) return REG_WINDOW;
    return REG_NONE;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] strb);
    merge_bytes = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merge_bytes[8*b +: 8] = wdata[8*b +: 8];
    end
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic flag_failure(input string msg);
    errors++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic reset_model;
    sh_mode   = 4'h0;
    sh_irq_en = 4'h0;
    sh_option = 2'h1;
    sh_lock   = 1'b0;
    sh_limit  = 8'h00;
    for (int w = 0; w < 4; w++) sh_win[w] = 32'h0;
  endtask

  // every input change happens 1 ns after the rising edge
  task automatic next_cycle;
    logic [31:0] r;
    @(posedge clk);
    #1;
    r = $urandom;
    if (event_hold_en) i_event = event_hold;
    else if (events_on && r[7:5] == 3'b000) i_event = r[3:0]; // sparse events
    else i_event = 4'h0;
  endtask

  task automatic check_fields;
    if (o_mode !== sh_mode) flag_mismatch("o_mode", 32'(o_mode), 32'(sh_mode));
    if (o_irq_en !== sh_irq_en) flag_mismatch("o_irq_en", 32'(o_irq_en), 32'(sh_irq_en));
    if (o_option !== sh_option) flag_mismatch("o_option", 32'(o_option), 32'(sh_option));
    if (o_lock !== sh_lock) flag_mismatch("o_lock", 32'(o_lock), 32'(sh_lock));
    if (o_limit !== sh_limit) flag_mismatch("o_limit", 32'(o_limit), 32'(sh_limit));
    if (o_irq !== m_irq) flag_mismatch("o_irq", 32'(o_irq), 32'(m_irq));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      next_cycle();
      if (o_irq !== m_irq) flag_mismatch("o_irq", 32'(o_irq), 32'(m_irq));
      if (o_trigger !== 4'h0) flag_mismatch("o_trigger", 32'(o_trigger), 32'h0);
    end
  endtask

  // ----------------------------------------
  // one APB transfer, checked against the shadow
  // ----------------------------------------
  task automatic apb_access(input logic write, input logic [15:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb);
    csr_reg_e    target;
    logic [15:0] rel;
    logic [1:0]  idx;
    logic [31:0] exp_rdata;
    logic [31:0] status_snap;
    logic [31:0] r;
    logic [3:0]  exp_trig;
    int          cyc;
    int          exp_cyc;
    target   = decode_addr(addr);
    rel      = addr - `CSR_BASE_ADDR;
    idx      = rel[3:2];
    exp_cyc  = (target == REG_WINDOW) ? 4 : 3; // the window adds one acknowledge cycle
    exp_trig = (write && target == REG_TRIGGER && strb[0]) ? wdata[3:0] : 4'h0;
    status_snap = 32'h0;
    xfers++;
    next_cycle();
    r = $urandom;
    i_hw_status = hw_random ? r[3:0] : 4'h0;
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = write;
    i_paddr   = addr;
    i_pwdata  = wdata;
    i_pstrb   = strb;
    next_cycle();
    i_penable = 1'b1;
    cyc = 1;
    while (o_pready !== 1'b1 && cyc <= 10) begin
      if (o_trigger !== 4'h0) flag_mismatch("o_trigger", 32'(o_trigger), 32'h0);
      next_cycle();
      cyc++;
      if (cyc == 2) begin
        status_snap = {12'h000, i_hw_status, 12'h000, m_flags};
        if (write && target == REG_STATUS && strb[0]) clear_pend = wdata[3:0];
      end else begin
        clear_pend = 4'h0;
      end
    end
    clear_pend = 4'h0;
    if (o_pready !== 1'b1) begin
      flag_failure($sformatf("no o_pready within 10 cycles for access to %h", addr));
    end else begin
      if (cyc != exp_cyc)
        flag_failure($sformatf("o_pready came in cycle %0d instead of %0d for %h",
                               cyc, exp_cyc, addr));
      if (o_pslverr !== (target == REG_NONE))
        flag_mismatch("o_pslverr", 32'(o_pslverr), 32'(target == REG_NONE));
      case (target)
        REG_CTRL:    exp_rdata = {18'h0, sh_option, 3'h0, sh_lock, sh_irq_en, sh_mode};
        REG_STATUS:  exp_rdata = status_snap;
        REG_LIMIT:   exp_rdata = {24'h0, sh_limit};
        REG_ID:      exp_rdata = `CSR_ID_VALUE;
        REG_WINDOW:  exp_rdata = sh_win[idx];
        REG_TRIGGER: exp_rdata = 32'h0;
        default:     exp_rdata = `CSR_DEFAULT_RDATA;
      endcase
      if (!write && o_prdata !== exp_rdata) flag_mismatch("o_prdata", o_prdata, exp_rdata);
      if (write) begin
        case (target)
          REG_CTRL: begin
            if (strb[0]) begin
              sh_mode   = wdata[3:0];
              sh_irq_en = wdata[7:4];
            end
            if (strb[1]) begin
              sh_lock   = wdata[8];
              sh_option = wdata[13:12];
            end
          end
          REG_LIMIT:  if (strb[0] && !sh_lock) sh_limit = wdata[7:0];
          REG_WINDOW: sh_win[idx] = merge_bytes(sh_win[idx], wdata, strb);
          default: ;
        endcase
      end
      if (o_trigger !== exp_trig) flag_mismatch("o_trigger", 32'(o_trigger), 32'(exp_trig));
      check_fields();
    end
    next_cycle();
    i_psel    = 1'b0;
    i_penable = 1'b0;
    if (o_pready !== 1'b0) flag_mismatch("o_pready", 32'(o_pready), 32'h0); // one cycle of ready
    if (o_trigger !== 4'h0) flag_mismatch("o_trigger", 32'(o_trigger), 32'h0); // one pulse only
  endtask

  task automatic start_test;
    test_err0  = errors;
    test_xfer0 = xfers;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-8s %4d transfers, %0d errors", name, xfers - test_xfer0,
             errors - test_err0);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic test_strobes;
    logic [3:0]  strb;
    logic [15:0] win_addr;
    for (int s = 1; s < 16; s++) begin
      strb     = 4'(s);
      win_addr = reg_addr(`CSR_OFS_WINDOW) + 16'(4 * (s % 4));
      apb_access(1'b1, reg_addr(`CSR_OFS_CTRL), $urandom, strb);
      apb_access(1'b0, reg_addr(`CSR_OFS_CTRL), 32'h0, 4'h0);
      apb_access(1'b1, reg_addr(`CSR_OFS_CTRL), 32'h0, 4'b0010); // unlock before LIMIT
      apb_access(1'b1, reg_addr(`CSR_OFS_LIMIT), $urandom, strb);
      apb_access(1'b0, reg_addr(`CSR_OFS_LIMIT), 32'h0, 4'h0);
      apb_access(1'b1, win_addr, $urandom, strb);
      apb_access(1'b0, win_addr, 32'h0, 4'h0);
      apb_access(1'b1, reg_addr(`CSR_OFS_TRIGGER), $urandom, strb);
    end
  endtask

  task automatic test_lock;
    apb_access(1'b1, reg_addr(`CSR_OFS_LIMIT), 32'h0000_003C, 4'hF);
    apb_access(1'b1, reg_addr(`CSR_OFS_CTRL), 32'h0000_0100, 4'b0010);
    apb_access(1'b1, reg_addr(`CSR_OFS_LIMIT), 32'h0000_00A5, 4'hF);
    apb_access(1'b0, reg_addr(`CSR_OFS_LIMIT), 32'h0, 4'h0);
    apb_access(1'b1, reg_addr(`CSR_OFS_CTRL), 32'h0000_0000, 4'b0010);
    apb_access(1'b1, reg_addr(`CSR_OFS_LIMIT), 32'h0000_005A, 4'hF);
    apb_access(1'b0, reg_addr(`CSR_OFS_LIMIT), 32'h0, 4'h0);
  endtask

  task automatic test_events;
    apb_access(1'b1, reg_addr(`CSR_OFS_CTRL), 32'h0000_00F0, 4'b0001);
    events_on = 1'b1;
    repeat (12) begin
      idle_cycles(6);
      apb_access(1'b0, reg_addr(`CSR_OFS_STATUS), 32'h0, 4'h0);
      apb_access(1'b1, reg_addr(`CSR_OFS_STATUS), $urandom, 4'b0001);
    end
    events_on = 1'b0;
    // events held through the clearing write keep their flags
    event_hold    = 4'b0101;
    event_hold_en = 1'b1;
    apb_access(1'b1, reg_addr(`CSR_OFS_STATUS), 32'h0000_000F, 4'b0001);
    event_hold_en = 1'b0;
    apb_access(1'b0, reg_addr(`CSR_OFS_STATUS), 32'h0, 4'h0);
    apb_access(1'b1, reg_addr(`CSR_OFS_CTRL), 32'h0000_00A0, 4'b0001); // mask two flags
    idle_cycles(3);
    apb_access(1'b1, reg_addr(`CSR_OFS_STATUS), 32'h0000_000F, 4'b0001);
    apb_access(1'b0, reg_addr(`CSR_OFS_STATUS), 32'h0, 4'h0);
  endtask

  task automatic test_random;
    logic [31:0] r;
    logic [7:0]  ofs;
    logic [15:0] addr;
    int          pick;
    events_on = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      r    = $urandom;
      pick = int'(r[31:28]) % 10;
      case (pick)
        0:       ofs = `CSR_OFS_CTRL;
        1:       ofs = `CSR_OFS_TRIGGER;
        2:       ofs = `CSR_OFS_STATUS;
        3:       ofs = `CSR_OFS_LIMIT;
        4:       ofs = `CSR_OFS_ID;
        5, 6:    ofs = `CSR_OFS_WINDOW + {4'h0, r[27:26], 2'b00};
        default: ofs = {r[25:20], 2'b00}; // anywhere in the page
      endcase
      addr = (pick == 9) ? {r[19:6], 2'b00} : reg_addr(ofs);
      apb_access(r[4], addr, $urandom, r[3:0]);
    end
    events_on = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    i_arst_n      = 1'b0;
    i_psel        = 1'b0;
    i_penable     = 1'b0;
    i_pwrite      = 1'b0;
    i_paddr       = 16'h0;
    i_pwdata      = 32'h0;
    i_pstrb       = 4'h0;
    i_event       = 4'h0;
    i_hw_status   = 4'h0;
    clear_pend    = 4'h0;
    events_on     = 1'b0;
    event_hold_en = 1'b0;
    event_hold    = 4'h0;
    hw_random     = 1'b0;
    reset_model();
    repeat (4) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    start_test();
    check_fields();
    if (o_trigger !== 4'h0) flag_mismatch("o_trigger", 32'(o_trigger), 32'h0);
    apb_access(1'b0, reg_addr(`CSR_OFS_CTRL), 32'h0, 4'h0);
    apb_access(1'b0, reg_addr(`CSR_OFS_STATUS), 32'h0, 4'h0);
    apb_access(1'b0, reg_addr(`CSR_OFS_LIMIT), 32'h0, 4'h0);
    apb_access(1'b0, reg_addr(`CSR_OFS_ID), 32'h0, 4'h0);
    end_test("reset");
    hw_random = 1'b1;

    start_test();
    test_strobes();
    end_test("strobes");
    start_test();
    test_lock();
    end_test("lock");
    start_test();
    test_events();
    end_test("events");
    start_test();
    foreach (BAD_ADDR[i]) begin
      apb_access(1'b0, BAD_ADDR[i], 32'h0, 4'h0);
      apb_access(1'b1, BAD_ADDR[i], $urandom, 4'hF);
    end
    end_test("unmapped");
    start_test();
    test_random();
    end_test("random");

    $display("summary: %0d tests, %0d transfers, %0d errors", tests, xfers, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/csr_bus_pkg.sv
logic/csr_map_pkg.sv
logic/csr_apb_front.sv
logic/csr_decoder.sv
logic/csr_control_regs.sv
logic/csr_event_regs.sv
logic/csr_window_regs.sv
logic/csr_top.sv
bench/csr_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
